// File: Makefile
VERILATOR ?= verilator
TOP       ?= board_io_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
BIN       ?= sim_bin
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(BIN)

sim: build
	-./$(BUILD_DIR)/$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/board_io_tb.sv
`timescale 1ns/10ps

module board_io_tb;
	import board_io_pkg::*;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              we;
		logic [3:0]        sel;
		logic [31:0]       wdata;
		logic              chk;	// compare read data
		logic [31:0]       exp;
	} row_t;

	localparam int N_ROWS = 18;

	// expected values follow the byte-enable rule by hand
	row_t stim_tbl [N_ROWS] = '{
		'{REG_LED,  1'b0, 4'h0, 32'h00000000, 1'b1, 32'h00000000},
		'{REG_DATA, 1'b0, 4'h0, 32'h00000000, 1'b1, 32'h00000000},
		'{REG_CTRL, 1'b0, 4'h0, 32'h00000000, 1'b1, 32'h00000000},
		'{REG_IRQ,  1'b0, 4'h0, 32'h00000000, 1'b1, 32'h00000000},
		'{REG_DATA, 1'b1, 4'hf, 32'h12345678, 1'b0, 32'h00000000},
		'{REG_DATA, 1'b1, 4'h5, 32'haabbccdd, 1'b0, 32'h00000000},
		'{REG_DATA, 1'b0, 4'h0, 32'h00000000, 1'b1, 32'h12bb56dd},
		'{REG_LED,  1'b1, 4'h2, 32'h0000a500, 1'b0, 32'h00000000},
		'{REG_LED,  1'b1, 4'h1, 32'hffffff3c, 1'b0, 32'h00000000},
		'{REG_LED,  1'b0, 4'h0, 32'h00000000, 1'b1, 32'h0000a53c},
		'{REG_CTRL, 1'b1, 4'h3, 32'hffff0f81, 1'b0, 32'h00000000},
		'{REG_CTRL, 1'b1, 4'h4, 32'h00ff0000, 1'b0, 32'h00000000},
		'{REG_CTRL, 1'b0, 4'h0, 32'h00000000, 1'b1, 32'h00000f81},
		'{6'd3,     1'b1, 4'hf, 32'hffffffff, 1'b0, 32'h00000000},
		'{6'd3,     1'b0, 4'h0, 32'h00000000, 1'b1, 32'h00000000},
		'{6'd63,    1'b0, 4'h0, 32'h00000000, 1'b1, 32'h00000000},
		'{6'd7,     1'b1, 4'hf, 32'hdeadbeef, 1'b0, 32'h00000000},
		'{6'd7,     1'b0, 4'h0, 32'h00000000, 1'b1, 32'h00000000}
	};

	logic        clk;
	logic        rst;
	logic [15:0] switch;
	logic [15:0] pressed;	// button model state
	logic [3:0]  btn_x;
	logic [3:0]  btn_y;
	bus_req_t    bus_req;
	bus_rsp_t    bus_rsp;
	logic        irq;
	logic        led_clk, led_clr_n, led_do;
	logic        seg_clk, seg_clr_n, seg_do;
	logic [15:0] cap_led;
	logic [63:0] cap_seg;
	logic        frame_done;
	int          errors;
	int          tests_pass;
	int          tests_fail;

	board_io_top uut (
		.clk(clk), .rst(rst), .switch_i(switch), .btn_x_i(btn_x), .btn_y_o(btn_y),
		.bus_i(bus_req), .bus_o(bus_rsp), .irq_o(irq),
		.led_clk_o(led_clk), .led_clr_n_o(led_clr_n), .led_do_o(led_do),
		.seg_clk_o(seg_clk), .seg_clr_n_o(seg_clr_n), .seg_do_o(seg_do)
	);

	serial_chain_capture u_cap (
		.clk(clk), .rst(rst), .clr_n_i(led_clr_n),
		.led_clk_i(led_clk), .led_do_i(led_do), .seg_clk_i(seg_clk), .seg_do_i(seg_do),
		.led_word_o(cap_led), .seg_word_o(cap_seg), .frame_done_o(frame_done)
	);

	// columns of the active row
	always_comb begin
		case (btn_y)
			4'b0001: btn_x = pressed[3:0];
			4'b0010: btn_x = pressed[7:4];
			4'b0100: btn_x = pressed[11:8];
			4'b1000: btn_x = pressed[15:12];
			default: btn_x = 4'h0;
		endcase
	end

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#2000000;
		$display("global time limit reached, the run did not finish");
		$display("Simulation failed");
		$finish;
	end

	task automatic report_mismatch(input string msg);
		$display("** Error [%0t] %s", $time, msg);
		errors++;
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			tests_pass++;
			$display("test %s: pass", name);
		end else begin
			tests_fail++;
			$display("test %s: FAIL (%0d errors)", name, errors - errs_before);
		end
	endtask

	task automatic bus_xfer(input logic [ADDR_W-1:0] a, input logic w, input logic [3:0] s,
		input logic [31:0] d, output logic [31:0] q);
		int n;
		bit got;
		n   = 0;
		got = 0;
		q   = 32'h0;
		@(posedge clk);
		bus_req.cs    <= 1'b1;
		bus_req.we    <= w;
		bus_req.addr  <= a;
		bus_req.sel   <= s;
		bus_req.wdata <= d;
		while (!got && n < 20) begin
			@(posedge clk);
			n++;
			if (bus_rsp.ack) begin
				got = 1;
				q   = bus_rsp.rdata;
			end
		end
		bus_req.cs <= 1'b0;
		bus_req.we <= 1'b0;
		if (!got) begin
			$display("no ack arrived for the access at word address %0d", a);
			errors++;
		end else begin
			@(posedge clk);
			assert (!bus_rsp.ack) else report_mismatch("ack longer than one cycle");
		end
	endtask

	task automatic wait_load();
		int n;
		n = 0;
		while (led_clr_n && n < 2000) begin
			@(posedge clk);
			n++;
		end
		if (led_clr_n) begin
			$display("no display frame started in time");
			errors++;
		end else begin
			assert (!seg_clr_n)
				else report_mismatch("segment chain not cleared with the led chain");
		end
	endtask

	task automatic wait_frame();
		int n;
		n = 0;
		while (!frame_done && n < 2000) begin
			@(posedge clk);
			n++;
		end
		if (!frame_done) begin
			$display("display frame did not complete in time");
			errors++;
		end
	endtask

	// built digit 7 down to 0, top byte first
	function automatic logic [63:0] predict_seg(logic [31:0] data, logic [7:0] en,
		logic [7:0] dot);
		logic [63:0] s;
		logic [7:0]  pat;
		s = 64'h0;
		for (int d = 7; d >= 0; d--) begin
			pat = SEG_FONT[data[d*4 +: 4]] & (dot[d] ? 8'h7f : 8'hff);
			s   = {s[55:0], en[d] ? pat : 8'hff};
		end
		return s;
	endfunction

	task automatic write_disp(input logic [15:0] l, input logic [31:0] d, input logic [15:0] c);
		logic [31:0] q;
		bus_xfer(REG_LED, 1'b1, 4'hf, {16'h0, l}, q);
		bus_xfer(REG_DATA, 1'b1, 4'hf, d, q);
		bus_xfer(REG_CTRL, 1'b1, 4'hf, {16'h0, c}, q);
	endtask

	task automatic check_frame(input logic [15:0] l, input logic [31:0] d, input logic [15:0] c);
		wait_load();
		wait_frame();
		assert (cap_led == l)
			else report_mismatch($sformatf("led chain %h, expected %h", cap_led, l));
		assert (cap_seg == predict_seg(d, c[15:8], c[7:0]))
			else report_mismatch($sformatf("segment chain %h, expected %h", cap_seg,
				predict_seg(d, c[15:8], c[7:0])));
	endtask

	initial begin
		logic [31:0] q;
		logic [15:0] l;
		logic [31:0] d;
		logic [15:0] c;
		int e0;
		int n;
		q = $urandom(32'h39ee41f4);
		errors     = 0;
		tests_pass = 0;
		tests_fail = 0;
		rst        = 1'b1;
		switch     = 16'h0;
		pressed    = 16'h0;
		bus_req    = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		repeat (4) @(posedge clk);

		e0 = errors;
		assert (!irq) else report_mismatch("irq high after reset");
		for (int i = 0; i < N_ROWS; i++) begin
			bus_xfer(stim_tbl[i].addr, stim_tbl[i].we, stim_tbl[i].sel, stim_tbl[i].wdata, q);
			if (stim_tbl[i].chk)
				assert (q == stim_tbl[i].exp)
					else report_mismatch($sformatf("row %0d read %h, expected %h", i, q,
						stim_tbl[i].exp));
		end
		end_test("register table", e0);

		e0 = errors;
		@(posedge clk);
		switch <= 16'($urandom());
		repeat (3) @(posedge clk);
		bus_xfer(REG_SWITCH, 1'b0, 4'h0, 32'h0, q);
		assert (q == {16'h0, switch}) else report_mismatch($sformatf("switch read %h", q));
		pressed <= 16'($urandom());
		n = 0;
		do begin
			bus_xfer(REG_BTN, 1'b0, 4'h0, 32'h0, q);
			n++;
		end while (q != {16'h0, pressed} && n < 40);
		assert (q == {16'h0, pressed})
			else report_mismatch($sformatf("button map %h, expected %h", q, pressed));
		end_test("switch and button read", e0);

		e0 = errors;
		repeat (4) @(posedge clk);
		bus_xfer(REG_IRQ, 1'b1, 4'h1, 32'h1, q);
		repeat (2) @(posedge clk);
		assert (!irq) else report_mismatch("irq not cleared before switch change");
		switch <= ~switch;
		n = 0;
		while (!irq && n < 50) begin
			@(posedge clk);
			n++;
		end
		if (!irq) begin
			$display("irq did not rise after a switch change");
			errors++;
		end
		bus_xfer(REG_IRQ, 1'b1, 4'h1, 32'h1, q);
		for (int i = 0; i < 20; i++) begin
			@(posedge clk);
			assert (!irq) else report_mismatch("irq high with stable inputs");
		end
		end_test("change interrupt", e0);

		e0 = errors;
		l = 16'($urandom());
		d = $urandom();
		c = 16'($urandom());
		write_disp(l, d, c);
		check_frame(l, d, c);
		end_test("display frame", e0);

		e0 = errors;
		write_disp(16'($urandom()), $urandom(), 16'($urandom()));
		wait_load();
		for (int k = 0; k < 3; k++) begin
			l = 16'($urandom());
			d = $urandom();
			c = 16'($urandom());
			write_disp(l, d, c);
		end
		check_frame(l, d, c);
		end_test("writes during a frame", e0);

		$display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, errors);
		if (errors == 0 && tests_fail == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: bench/serial_chain_capture.sv
`timescale 1ns/10ps

module serial_chain_capture (
	input  logic        clk,
	input  logic        rst,
	input  logic        clr_n_i,
	input  logic        led_clk_i,
	input  logic        led_do_i,
	input  logic        seg_clk_i,
	input  logic        seg_do_i,
	output logic [15:0] led_word_o,
	output logic [63:0] seg_word_o,
	output logic        frame_done_o
);
	logic        led_clk_d;
	logic        seg_clk_d;
	logic [15:0] led_sr;	// last 16 led bits seen
	logic [63:0] seg_sr;
	logic [6:0]  seg_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			led_clk_d    <= 1'b0;
			seg_clk_d    <= 1'b0;
			led_sr       <= 16'h0;
			seg_sr       <= 64'h0;
			seg_cnt      <= 7'd0;
			led_word_o   <= 16'h0;
			seg_word_o   <= 64'h0;
			frame_done_o <= 1'b0;
		end else begin
			led_clk_d    <= led_clk_i;
			seg_clk_d    <= seg_clk_i;
			frame_done_o <= 1'b0;
			if (!clr_n_i) begin
				seg_cnt <= 7'd0;	// new frame starts
			end else begin
				if (led_clk_i && !led_clk_d)
					led_sr <= {led_sr[14:0], led_do_i};
				if (seg_clk_i && !seg_clk_d) begin
					seg_sr <= {seg_sr[62:0], seg_do_i};
					if (seg_cnt == 7'd63) begin
						seg_cnt      <= 7'd0;
						led_word_o   <= led_sr;
						seg_word_o   <= {seg_sr[62:0], seg_do_i};
						frame_done_o <= 1'b1;
					end else begin
						seg_cnt <= seg_cnt + 7'd1;
					end
				end
			end
		end
	end

endmodule

// File: hw/board_io_pkg.sv
package board_io_pkg;

	localparam int ADDR_W = 6;	// word address, byte address bits 7:2

	// register map, word addresses
	localparam logic [ADDR_W-1:0] REG_SWITCH = ADDR_W'(0);
	localparam logic [ADDR_W-1:0] REG_BTN    = ADDR_W'(1);
	localparam logic [ADDR_W-1:0] REG_IRQ    = ADDR_W'(2);
	localparam logic [ADDR_W-1:0] REG_LED    = ADDR_W'(4);
	localparam logic [ADDR_W-1:0] REG_DATA   = ADDR_W'(5);
	localparam logic [ADDR_W-1:0] REG_CTRL   = ADDR_W'(6);

	localparam int SCAN_DIV  = 8;	// cycles per button row
	localparam int SHIFT_DIV = 2;	// cycles per half shift clock
	localparam int SCAN_CNT_W  = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
	localparam int SHIFT_CNT_W = (SHIFT_DIV > 1) ? $clog2(SHIFT_DIV) : 1;

	// hex font, active low, point in bit 7 (off)
	localparam logic [7:0] SEG_FONT [16] = '{
		8'hc0, 8'hf9, 8'ha4, 8'hb0,
		8'h99, 8'h92, 8'h82, 8'hf8,
		8'h80, 8'h90, 8'h88, 8'h83,
		8'hc6, 8'ha1, 8'h86, 8'h8e
	};

	typedef struct packed {
		logic              cs;
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [3:0]        sel;
		logic [31:0]       wdata;
	} bus_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] rdata;
	} bus_rsp_t;

	typedef struct packed {
		logic [15:0] led;
		logic [31:0] data;	// one nibble per digit
		logic [7:0]  en;
		logic [7:0]  dot;
	} disp_state_t;

	typedef enum logic [2:0] {IDLE, LOAD, LED_BITS, SEG_BITS, DONE} shift_state_e;

endpackage

// File: hw/board_io_regs.sv
`timescale 1ns/10ps

module board_io_regs (
	input  logic                      clk,
	input  logic                      rst,
	input  board_io_pkg::bus_req_t    bus_i,
	output board_io_pkg::bus_rsp_t    bus_o,
	input  logic [15:0]               switch_i,
	input  logic [15:0]               btn_map_i,
	output logic                      irq_o,
	output board_io_pkg::disp_state_t disp_o,
	output logic                      disp_req_o,
	input  logic                      disp_ack_i
);
	import board_io_pkg::*;

	disp_state_t disp_q;	// led, data, en, dot
	logic        ack_q;
	logic [31:0] rdata_q;
	logic [31:0] rd_word;	// current value at the bus address
	logic [31:0] wr_word;	// rd_word with the selected bytes replaced
	logic        acc;
	logic        wr_en;
	logic        disp_wr;
	logic        irq_clr;
	logic [31:0] in_q;
	logic [31:0] in_prev;
	logic        in_change;
	logic        irq_q;
	logic        dirty_q;
	logic        req_q;
	logic        launch;

	// a new access only while ack is low
	assign acc   = bus_i.cs & ~ack_q;
	assign wr_en = acc & bus_i.we;

	always_comb begin
		case (bus_i.addr)
			REG_SWITCH: rd_word = {16'h0, switch_i};
			REG_BTN:    rd_word = {16'h0, btn_map_i};
			REG_IRQ:    rd_word = {31'h0, irq_q};
			REG_LED:    rd_word = {16'h0, disp_q.led};
			REG_DATA:   rd_word = disp_q.data;
			REG_CTRL:   rd_word = {16'h0, disp_q.en, disp_q.dot};
			default:    rd_word = 32'h0;	// unmapped reads zero
		endcase
	end

	// byte enables applied on top of the old value
	always_comb begin
		for (int i = 0; i < 4; i++)
			wr_word[i*8 +: 8] = bus_i.sel[i] ? bus_i.wdata[i*8 +: 8] : rd_word[i*8 +: 8];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q   <= 1'b0;
			rdata_q <= 32'h0;
		end else begin
			ack_q   <= acc;	// single cycle pulse
			rdata_q <= acc ? rd_word : 32'h0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			disp_q <= '0;
		end else if (wr_en) begin
			case (bus_i.addr)
				REG_LED:  disp_q.led  <= wr_word[15:0];
				REG_DATA: disp_q.data <= wr_word;
				REG_CTRL: begin
					disp_q.en  <= wr_word[15:8];
					disp_q.dot <= wr_word[7:0];
				end
				default: ;	// read only or unmapped
			endcase
		end
	end

	// input change detect, first stage also syncs the switches
	always_ff @(posedge clk) begin
		in_q    <= {switch_i, btn_map_i};
		in_prev <= in_q;
	end

	assign in_change = (in_q != in_prev);
	assign irq_clr   = wr_en && (bus_i.addr == REG_IRQ) && bus_i.sel[0] && bus_i.wdata[0];

	always_ff @(posedge clk) begin
		if (rst)
			irq_q <= 1'b0;
		else if (in_change)
			irq_q <= 1'b1;	// change wins over clear
		else if (irq_clr)
			irq_q <= 1'b0;
	end

	assign disp_wr = wr_en && ((bus_i.addr == REG_LED) || (bus_i.addr == REG_DATA) ||
		(bus_i.addr == REG_CTRL));

	// start a refresh only when the previous handshake is fully closed
	assign launch = dirty_q & ~req_q & ~disp_ack_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			dirty_q <= 1'b0;
			req_q   <= 1'b0;
		end else begin
			if (disp_wr)
				dirty_q <= 1'b1;	// merges writes made during a frame
			else if (launch)
				dirty_q <= 1'b0;

			if (launch)
				req_q <= 1'b1;
			else if (disp_ack_i)
				req_q <= 1'b0;
		end
	end

	assign bus_o.ack   = ack_q;
	assign bus_o.rdata = rdata_q;
	assign irq_o       = irq_q;
	assign disp_o      = disp_q;
	assign disp_req_o  = req_q;

endmodule

// File: hw/board_io_top.sv
`timescale 1ns/10ps

module board_io_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [15:0]            switch_i,
	input  logic [3:0]             btn_x_i,
	output logic [3:0]             btn_y_o,
	input  board_io_pkg::bus_req_t bus_i,
	output board_io_pkg::bus_rsp_t bus_o,
	output logic                   irq_o,
	output logic                   led_clk_o,
	output logic                   led_clr_n_o,
	output logic                   led_do_o,
	output logic                   seg_clk_o,
	output logic                   seg_clr_n_o,
	output logic                   seg_do_o
);
	import board_io_pkg::*;

	logic [15:0] btn_map;
	disp_state_t disp_state;	// register copy of the display
	logic        disp_req;
	logic        disp_ack;

	btn_matrix_scan u_scan (
		.clk       (clk),
		.rst       (rst),
		.btn_x_i   (btn_x_i),
		.btn_y_o   (btn_y_o),
		.btn_map_o (btn_map)
	);

	board_io_regs u_regs (
		.clk        (clk),
		.rst        (rst),
		.bus_i      (bus_i),
		.bus_o      (bus_o),
		.switch_i   (switch_i),
		.btn_map_i  (btn_map),
		.irq_o      (irq_o),
		.disp_o     (disp_state),
		.disp_req_o (disp_req),
		.disp_ack_i (disp_ack)
	);

	serial_disp_shift u_shift (
		.clk         (clk),
		.rst         (rst),
		.disp_i      (disp_state),
		.req_i       (disp_req),
		.ack_o       (disp_ack),
		.led_clk_o   (led_clk_o),
		.led_clr_n_o (led_clr_n_o),
		.led_do_o    (led_do_o),
		.seg_clk_o   (seg_clk_o),
		.seg_clr_n_o (seg_clr_n_o),
		.seg_do_o    (seg_do_o)
	);

endmodule

// File: hw/btn_matrix_scan.sv
`timescale 1ns/10ps

module btn_matrix_scan (
	input  logic        clk,
	input  logic        rst,
	input  logic [3:0]  btn_x_i,
	output logic [3:0]  btn_y_o,
	output logic [15:0] btn_map_o
);
	import board_io_pkg::*;

	logic [SCAN_CNT_W-1:0] div_q;	// position inside the row window
	logic [1:0]            row_q;
	logic                  win_end;

	assign win_end = (div_q == SCAN_CNT_W'(SCAN_DIV - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			div_q <= '0;
			row_q <= 2'd0;
		end else begin
			div_q <= win_end ? '0 : div_q + 1'b1;
			if (win_end)
				row_q <= row_q + 2'd1;	// wraps after row 3
		end
	end

	// columns are sampled once, at the close of each window
	always_ff @(posedge clk) begin
		if (rst)
			btn_map_o <= 16'h0;
		else if (win_end)
			btn_map_o[row_q*4 +: 4] <= btn_x_i;
	end

	// one hot row drive
	assign btn_y_o = 4'b0001 << row_q;

endmodule

// File: hw/serial_disp_shift.sv
`timescale 1ns/10ps

module serial_disp_shift (
	input  logic                      clk,
	input  logic                      rst,
	input  board_io_pkg::disp_state_t disp_i,
	input  logic                      req_i,
	output logic                      ack_o,
	output logic                      led_clk_o,
	output logic                      led_clr_n_o,
	output logic                      led_do_o,
	output logic                      seg_clk_o,
	output logic                      seg_clr_n_o,
	output logic                      seg_do_o
);
	import board_io_pkg::*;

	shift_state_e           state_q;
	logic [SHIFT_CNT_W-1:0] div_q;
	logic                   half_end;	// end of a shift clock half period
	logic [5:0]             bit_q;	// bits left in the chain, minus one
	logic [15:0]            led_word_q;
	logic [63:0]            seg_word_q;
	logic                   led_clk_q;
	logic                   seg_clk_q;
	logic                   clr_n_q;
	logic                   ack_q;

	// digit 7 lands in the top byte so it leaves first
	function automatic logic [63:0] seg_encode(disp_state_t d);
		logic [63:0] w;
		logic [7:0]  b;
		for (int i = 0; i < 8; i++) begin
			b = SEG_FONT[d.data[i*4 +: 4]];
			if (d.dot[i])
				b[7] = 1'b0;	// point on
			w[i*8 +: 8] = d.en[i] ? b : 8'hff;	// disabled digit is dark
		end
		return w;
	endfunction

	assign half_end = (div_q == SHIFT_CNT_W'(SHIFT_DIV - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q   <= IDLE;
			div_q     <= '0;
			bit_q     <= 6'd0;
			led_clk_q <= 1'b0;
			seg_clk_q <= 1'b0;
			clr_n_q   <= 1'b1;
			ack_q     <= 1'b0;
		end else begin
			case (state_q)
				IDLE: if (req_i) begin
					state_q <= LOAD;
					clr_n_q <= 1'b0;	// clear both chains for one cycle
				end
				LOAD: begin
					clr_n_q <= 1'b1;
					div_q   <= '0;
					bit_q   <= 6'd15;
					state_q <= LED_BITS;
				end
				LED_BITS: begin
					div_q <= half_end ? '0 : div_q + 1'b1;
					if (half_end) begin
						led_clk_q <= ~led_clk_q;
						if (led_clk_q) begin	// falling edge, bit done
							if (bit_q == 6'd0) begin
								bit_q   <= 6'd63;
								state_q <= SEG_BITS;
							end else begin
								bit_q <= bit_q - 6'd1;
							end
						end
					end
				end
				SEG_BITS: begin
					div_q <= half_end ? '0 : div_q + 1'b1;
					if (half_end) begin
						seg_clk_q <= ~seg_clk_q;
						if (seg_clk_q) begin
							if (bit_q == 6'd0) begin
								ack_q   <= 1'b1;	// frame out
								state_q <= DONE;
							end else begin
								bit_q <= bit_q - 6'd1;
							end
						end
					end
				end
				DONE: if (!req_i) begin
					ack_q   <= 1'b0;
					state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// snapshot in LOAD, then shift left after each falling edge
	always_ff @(posedge clk) begin
		if (rst) begin
			led_word_q <= 16'h0;
			seg_word_q <= 64'h0;
		end else if (state_q == LOAD) begin
			led_word_q <= disp_i.led;
			seg_word_q <= seg_encode(disp_i);
		end else if (half_end) begin
			if (state_q == LED_BITS && led_clk_q)
				led_word_q <= {led_word_q[14:0], 1'b0};
			if (state_q == SEG_BITS && seg_clk_q)
				seg_word_q <= {seg_word_q[62:0], 1'b0};
		end
	end

	assign ack_o       = ack_q;
	assign led_clk_o   = led_clk_q;
	assign seg_clk_o   = seg_clk_q;
	assign led_clr_n_o = clr_n_q;
	assign seg_clr_n_o = clr_n_q;
	assign led_do_o    = led_word_q[15];	// msb first
	assign seg_do_o    = seg_word_q[63];

endmodule

// File: sim.f
hw/board_io_pkg.sv
hw/btn_matrix_scan.sv
hw/serial_disp_shift.sv
hw/board_io_regs.sv
hw/board_io_top.sv
bench/serial_chain_capture.sv
bench/board_io_tb.sv
